// ==== verilog/sdp_pkg.sv ====
// section phase encoding and byte width constant for the section data path

package sdp_pkg;

	// ------------------------------
	// section phases
	// ------------------------------

	// idle waits for a start strobe
	// input collects one section from the source port
	// output unloads the collected section to the destination port
	typedef enum logic [1:0] {
		PH_IDLE   = 2'd0,
		PH_INPUT  = 2'd1,
		PH_OUTPUT = 2'd2
	} sdp_phase_e;

	// ------------------------------
	// byte geometry
	// ------------------------------

	// bits per byte lane of the strobe and load logic
	localparam int SDP_BYTE_W = 8;

endpackage

// ==== verilog/sdp_phase_ctrl.sv ====
// section phase FSM and registered input ready flag

module sdp_phase_ctrl
	import sdp_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       i_en,
	input  logic       i_transfer_pending,
	input  logic       i_input_done,
	input  logic       i_output_done,
	output sdp_phase_e o_phase,
	output logic       o_din_ready
);

	sdp_phase_e phase_q;
	sdp_phase_e phase_d;
	logic       din_ready_q;
	logic       din_ready_d;

	// ------------------------------
	// next phase
	// ------------------------------

	always_comb begin
		phase_d = phase_q;
		case (phase_q)
			PH_IDLE: begin
				if (i_en) begin
					phase_d = PH_INPUT;
				end
			end
			PH_INPUT: begin
				if (i_input_done) begin
					phase_d = PH_OUTPUT;
				end
			end
			PH_OUTPUT: begin
				// another section follows directly while pending is high
				if (i_output_done) begin
					phase_d = i_transfer_pending ? PH_INPUT : PH_IDLE;
				end
			end
			default: begin
				phase_d = PH_IDLE;
			end
		endcase
	end

	// ready rises and falls on the same events as PH_INPUT
	always_comb begin
		case (phase_q)
			PH_IDLE:   din_ready_d = i_en;
			PH_INPUT:  din_ready_d = ~i_input_done;
			PH_OUTPUT: din_ready_d = i_output_done & i_transfer_pending;
			default:   din_ready_d = 1'b0;
		endcase
	end

	// ------------------------------
	// state registers
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q     <= PH_IDLE;
			din_ready_q <= 1'b0;
		end else begin
			phase_q     <= phase_d;
			din_ready_q <= din_ready_d;
		end
	end

	assign o_phase     = phase_q;
	assign o_din_ready = din_ready_q;

endmodule

// ==== verilog/sdp_input_packer.sv ====
// strobe counter, byte packing into the section buffer and input done detection

module sdp_input_packer
	import sdp_pkg::*;
#(
	parameter int DATA_W = 512,
	parameter int CNT_W  = 7
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  sdp_phase_e                 i_phase,
	input  logic [CNT_W-1:0]           i_num_bytes,
	input  logic                       i_din_vld,
	input  logic                       i_din_ready,
	input  logic [DATA_W-1:0]          i_din,
	input  logic [DATA_W/SDP_BYTE_W-1:0] i_din_strb,
	output logic [DATA_W-1:0]          o_buffer,
	output logic                       o_input_done
);

	localparam int STRB_W = DATA_W / SDP_BYTE_W;
	localparam int OFF_W  = CNT_W + $clog2(SDP_BYTE_W);

	logic [CNT_W-1:0]  din_cnt;
	logic [CNT_W-1:0]  strb_num;
	logic [CNT_W-1:0]  cnt_next;
	logic [OFF_W-1:0]  bit_off;
	logic [DATA_W-1:0] din_shifted;
	logic [STRB_W-1:0] strb_shifted;
	logic [DATA_W-1:0] buf_q;
	logic              accept;

	// ------------------------------
	// strobe count and section count
	// ------------------------------

	// number of strobed bytes in this beat
	always_comb begin
		strb_num = '0;
		for (int i = 0; i < STRB_W; i++) begin
			strb_num = strb_num + CNT_W'(i_din_strb[i]);
		end
	end

	assign accept       = (i_phase == PH_INPUT) && i_din_vld && i_din_ready;
	assign cnt_next     = din_cnt + strb_num;
	assign o_input_done = accept && (cnt_next == i_num_bytes);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			din_cnt <= '0;
		end else if (i_phase != PH_INPUT || o_input_done) begin
			din_cnt <= '0;
		end else if (accept) begin
			din_cnt <= cnt_next;
		end
	end

	// ------------------------------
	// byte placement
	// ------------------------------

	// move the beat up to the first free byte of the buffer
	assign bit_off      = OFF_W'(din_cnt * SDP_BYTE_W);
	assign din_shifted  = i_din << bit_off;
	assign strb_shifted = i_din_strb << din_cnt;

	always_ff @(posedge clk) begin
		if (accept) begin
			for (int i = 0; i < STRB_W; i++) begin
				if (strb_shifted[i]) begin
					buf_q[i*SDP_BYTE_W +: SDP_BYTE_W] <= din_shifted[i*SDP_BYTE_W +: SDP_BYTE_W];
				end
			end
		end
	end

	assign o_buffer = buf_q;

endmodule

// ==== verilog/sdp_output_loader.sv ====
// output byte counter, right-aligned byte selection and registered output beat

module sdp_output_loader
	import sdp_pkg::*;
#(
	parameter int DATA_W = 512,
	parameter int CNT_W  = 7
) (
	input  logic              clk,
	input  logic              rst_n,
	input  sdp_phase_e        i_phase,
	input  logic [CNT_W-1:0]  i_num_bytes,
	input  logic [DATA_W-1:0] i_buffer,
	input  logic              i_dout_ready,
	input  logic [CNT_W-1:0]  i_dout_ldb_num,
	output logic [DATA_W-1:0] o_dout,
	output logic              o_dout_vld,
	output logic              o_output_done
);

	localparam int LANES = DATA_W / SDP_BYTE_W;
	localparam int OFF_W = CNT_W + $clog2(SDP_BYTE_W);

	logic [CNT_W-1:0]  dout_cnt;
	logic [OFF_W-1:0]  bit_off;
	logic [DATA_W-1:0] buf_shifted;
	logic [DATA_W-1:0] lane_mask;
	logic [DATA_W-1:0] dout_q;
	logic              dout_vld_q;
	logic              load;

	// ------------------------------
	// load control
	// ------------------------------

	// the done cycle closes the section without loading bytes
	assign o_output_done = (i_phase == PH_OUTPUT) && i_dout_ready && (dout_cnt == i_num_bytes);
	assign load          = (i_phase == PH_OUTPUT) && i_dout_ready && !o_output_done;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dout_cnt <= '0;
		end else if (i_phase != PH_OUTPUT || o_output_done) begin
			dout_cnt <= '0;
		end else if (load) begin
			dout_cnt <= dout_cnt + i_dout_ldb_num;
		end
	end

	// ------------------------------
	// byte selection
	// ------------------------------

	// bring byte dout_cnt down to lane 0
	assign bit_off     = OFF_W'(dout_cnt * SDP_BYTE_W);
	assign buf_shifted = i_buffer >> bit_off;

	// keep only the lanes covered by this load
	always_comb begin
		lane_mask = '0;
		for (int i = 0; i < LANES; i++) begin
			if (i < int'(i_dout_ldb_num)) begin
				lane_mask[i*SDP_BYTE_W +: SDP_BYTE_W] = '1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dout_vld_q <= 1'b0;
		end else begin
			dout_vld_q <= load;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			dout_q <= buf_shifted & lane_mask;
		end
	end

	assign o_dout     = dout_q;
	assign o_dout_vld = dout_vld_q;

endmodule

// ==== verilog/sdp_data_path.sv ====
// section data path top with phase controller, input packer and output loader

module sdp_data_path
	import sdp_pkg::*;
#(
	parameter int DATA_W = 512,
	parameter int CNT_W  = 7
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         i_en,
	input  logic [CNT_W-1:0]             i_num_bytes,
	input  logic                         i_transfer_pending,
	// source port
	input  logic                         i_din_vld,
	input  logic [DATA_W-1:0]            i_din,
	input  logic [DATA_W/SDP_BYTE_W-1:0] i_din_strb,
	output logic                         o_din_ready,
	// destination port
	input  logic                         i_dout_ready,
	input  logic [CNT_W-1:0]             i_dout_ldb_num,
	output logic [DATA_W-1:0]            o_dout,
	output logic                         o_dout_vld,
	// section events
	output logic                         o_input_section_done,
	output logic                         o_output_section_done
);

	sdp_phase_e        phase;
	logic [DATA_W-1:0] section_buf;

	// ------------------------------
	// phase control
	// ------------------------------

	sdp_phase_ctrl sdp_phase_ctrl_i (
		.clk                (clk),
		.rst_n              (rst_n),
		.i_en               (i_en),
		.i_transfer_pending (i_transfer_pending),
		.i_input_done       (o_input_section_done),
		.i_output_done      (o_output_section_done),
		.o_phase            (phase),
		.o_din_ready        (o_din_ready)
	);

	// ------------------------------
	// data movement
	// ------------------------------

	sdp_input_packer #(
		.DATA_W (DATA_W),
		.CNT_W  (CNT_W)
	) sdp_input_packer_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_phase      (phase),
		.i_num_bytes  (i_num_bytes),
		.i_din_vld    (i_din_vld),
		.i_din_ready  (o_din_ready),
		.i_din        (i_din),
		.i_din_strb   (i_din_strb),
		.o_buffer     (section_buf),
		.o_input_done (o_input_section_done)
	);

	sdp_output_loader #(
		.DATA_W (DATA_W),
		.CNT_W  (CNT_W)
	) sdp_output_loader_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_phase        (phase),
		.i_num_bytes    (i_num_bytes),
		.i_buffer       (section_buf),
		.i_dout_ready   (i_dout_ready),
		.i_dout_ldb_num (i_dout_ldb_num),
		.o_dout         (o_dout),
		.o_dout_vld     (o_dout_vld),
		.o_output_done  (o_output_section_done)
	);

endmodule

// ==== sim/tb_sdp_ref.svh ====
// reference output word model and section stimulus tasks for the section data path testbench
`ifndef TB_SDP_REF_SVH
`define TB_SDP_REF_SVH

// expected output word for a load of ldb bytes starting at section byte cnt
function automatic logic [DATA_W-1:0] ref_load(input logic [7:0] sec[$], input int cnt,
	input int ldb);
	logic [DATA_W-1:0] word;
	word = '0;
	for (int i = 0; i < ldb; i++) begin
		word[i*8 +: 8] = sec[cnt+i];
	end
	return word;
endfunction

// ------------------------------
// source side
// ------------------------------

// beat_w of 0 picks 1, 4 or 64 bytes at random and clips the width to what is left
task automatic send_section(input int n, input int beat_w, input bit gaps);
	int cnt;
	int w;
	int pick;
	cnt = 0;
	while (cnt < n) begin
		@(negedge clk);
		if (gaps && $urandom_range(0, 3) == 0) begin
			i_din_vld = 1'b0;
		end else begin
			if (beat_w > 0) begin
				w = beat_w;
			end else begin
				pick = int'($urandom_range(0, 2));
				w = (pick == 0) ? 1 : (pick == 1) ? 4 : 64;
			end
			while (w > n - cnt) begin
				w = (w == 64) ? 4 : 1;
			end
			// unused lanes carry garbage that the strobes must mask
			for (int i = 0; i < LANES; i++) begin
				if (i < w) begin
					i_din[i*8 +: 8] = sec_q[cnt+i];
					i_din_strb[i]   = 1'b1;
				end else begin
					i_din[i*8 +: 8] = 8'($urandom);
					i_din_strb[i]   = 1'b0;
				end
			end
			i_din_vld = 1'b1;
			if (o_din_ready) begin
				cnt += w;
			end
		end
	end
	@(negedge clk);
	i_din_vld  = 1'b0;
	i_din_strb = '0;
endtask

// ------------------------------
// destination side
// ------------------------------

// ld_w of 0 picks a random load width within the remaining count
task automatic unload_section(input int n, input int ld_w, input bit gaps);
	int cnt;
	int ldb;
	cnt = 0;
	while (cnt < n) begin
		@(negedge clk);
		if (gaps && $urandom_range(0, 3) == 0) begin
			i_dout_ready = 1'b0;
			load_exp     = 1'b0;
		end else begin
			ldb = (ld_w > 0) ? ld_w : int'($urandom_range(1, n - cnt));
			if (ldb > n - cnt) begin
				ldb = n - cnt;
			end
			i_dout_ready   = 1'b1;
			i_dout_ldb_num = CNT_W'(ldb);
			load_exp       = 1'b1;
			exp_q.push_back(ref_load(sec_q, cnt, ldb));
			cnt += ldb;
		end
	end
	// one more ready cycle closes the section
	@(negedge clk);
	i_dout_ready = 1'b1;
	load_exp     = 1'b0;
	@(negedge clk);
	i_dout_ready = 1'b0;
endtask

`endif

// ==== sim/tb_sdp_data_path.sv ====
// testbench top with clock, reset, DUT, checker, watchdog and tests for the section data path

module tb_sdp_data_path;

	localparam int DATA_W        = 512;
	localparam int CNT_W         = 7;
	localparam int LANES         = DATA_W / 8;
	localparam int RAND_SECTIONS = 16;
	localparam int TOTAL_BEATS   = 100 + RAND_SECTIONS * 128;

	logic              clk;
	logic              rst_n;
	logic              i_en;
	logic [CNT_W-1:0]  i_num_bytes;
	logic              i_transfer_pending;
	logic              i_din_vld;
	logic [DATA_W-1:0] i_din;
	logic [LANES-1:0]  i_din_strb;
	logic              o_din_ready;
	logic              i_dout_ready;
	logic [CNT_W-1:0]  i_dout_ldb_num;
	logic [DATA_W-1:0] o_dout;
	logic              o_dout_vld;
	logic              o_input_section_done;
	logic              o_output_section_done;

	logic [7:0]        sec_q[$];
	logic [DATA_W-1:0] exp_q[$];
	logic              load_exp;
	logic              load_prev;
	logic [DATA_W-1:0] exp_word;
	int                err_cnt;
	int                in_done_cnt;
	int                out_done_cnt;
	int                tests_run;
	int                tests_failed;

	`include "tb_sdp_ref.svh"

	sdp_data_path #(
		.DATA_W (DATA_W),
		.CNT_W  (CNT_W)
	) sdp_data_path_i (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.i_en                  (i_en),
		.i_num_bytes           (i_num_bytes),
		.i_transfer_pending    (i_transfer_pending),
		.i_din_vld             (i_din_vld),
		.i_din                 (i_din),
		.i_din_strb            (i_din_strb),
		.o_din_ready           (o_din_ready),
		.i_dout_ready          (i_dout_ready),
		.i_dout_ldb_num        (i_dout_ldb_num),
		.o_dout                (o_dout),
		.o_dout_vld            (o_dout_vld),
		.o_input_section_done  (o_input_section_done),
		.o_output_section_done (o_output_section_done)
	);

	always #5 clk = ~clk;

	// ------------------------------
	// checker
	// ------------------------------

	// o_dout_vld must follow the load of the previous edge
	always @(posedge clk) begin
		if (o_input_section_done) in_done_cnt++;
		if (o_output_section_done) out_done_cnt++;
		assert (o_dout_vld == load_prev) else begin
			$display("ERR %0t o_dout_vld exp=%0b got=%0b", $time, load_prev, o_dout_vld);
			err_cnt++;
		end
		if (o_dout_vld) begin
			assert (exp_q.size() != 0) else begin
				$display("output word at %0t arrived with no load pending", $time);
				err_cnt++;
			end
			if (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				assert (o_dout == exp_word) else begin
					$display("ERR %0t o_dout exp=%h got=%h", $time, exp_word, o_dout);
					err_cnt++;
				end
			end
		end
		load_prev = load_exp;
	end

	initial begin
		repeat (TOTAL_BEATS * 20 + 200) @(posedge clk);
		$display("timeout: the tests did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

	// ------------------------------
	// test helpers
	// ------------------------------

	task automatic run_section(input int n, input int in_w, input int ld_w, input bit gaps,
		input bit start);
		int in0;
		int out0;
		in0 = in_done_cnt;
		out0 = out_done_cnt;
		sec_q.delete();
		for (int i = 0; i < n; i++) begin
			sec_q.push_back(8'($urandom));
		end
		i_num_bytes = CNT_W'(n);
		if (start) begin
			@(negedge clk);
			i_en = 1'b1;
			@(negedge clk);
			i_en = 1'b0;
		end
		send_section(n, in_w, gaps);
		unload_section(n, ld_w, gaps);
		assert (in_done_cnt - in0 == 1) else begin
			$display("%0d input done pulses seen for a %0d-byte section", in_done_cnt - in0, n);
			err_cnt++;
		end
		assert (out_done_cnt - out0 == 1) else begin
			$display("%0d output done pulses seen for a %0d-byte section", out_done_cnt - out0, n);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (err_cnt != err_before) begin
			tests_failed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		int e0;
		void'($urandom(32'h2ea87254));
		clk = 1'b0;
		rst_n = 1'b0;
		i_en = 1'b0;
		i_num_bytes = '0;
		i_transfer_pending = 1'b0;
		i_din_vld = 1'b0;
		i_din = '0;
		i_din_strb = '0;
		i_dout_ready = 1'b0;
		i_dout_ldb_num = CNT_W'(1);
		load_exp = 1'b0;
		load_prev = 1'b0;
		err_cnt = 0;
		in_done_cnt = 0;
		out_done_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		e0 = err_cnt;
		repeat (20) begin
			@(negedge clk);
			assert (!(o_din_ready || o_dout_vld ||
				o_input_section_done || o_output_section_done)) else begin
				$display("outputs active at %0t without a start strobe", $time);
				err_cnt++;
			end
		end
		report_test("idle after reset", e0);

		e0 = err_cnt;
		run_section(32, 4, 8, 1'b0, 1'b1);
		report_test("32 bytes in 4-byte beats", e0);

		e0 = err_cnt;
		run_section(64, 64, 64, 1'b0, 1'b1);
		run_section(5, 1, 2, 1'b0, 1'b1);
		report_test("full and partial masking", e0);

		e0 = err_cnt;
		i_transfer_pending = 1'b1;
		run_section(16, 4, 8, 1'b0, 1'b1);
		assert (o_din_ready) else begin
			$display("input ready did not return after the first pending section");
			err_cnt++;
		end
		run_section(16, 4, 8, 1'b0, 1'b0);
		assert (o_din_ready) else begin
			$display("input ready did not return after the second pending section");
			err_cnt++;
		end
		i_transfer_pending = 1'b0;
		run_section(16, 4, 8, 1'b0, 1'b0);
		repeat (5) begin
			assert (!o_din_ready) else begin
				$display("input ready high at %0t after the last section", $time);
				err_cnt++;
			end
			@(negedge clk);
		end
		report_test("multi-section transfer", e0);

		e0 = err_cnt;
		for (int s = 0; s < RAND_SECTIONS; s++) begin
			run_section(int'($urandom_range(1, 64)), 0, 0, 1'b1, 1'b1);
		end
		report_test("random sections", e0);

		repeat (3) @(negedge clk);
		assert (exp_q.size() == 0) else begin
			$display("%0d expected output words never arrived", exp_q.size());
			err_cnt++;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+sim
verilog/sdp_pkg.sv
verilog/sdp_phase_ctrl.sv
verilog/sdp_input_packer.sv
verilog/sdp_output_loader.sv
verilog/sdp_data_path.sv
sim/tb_sdp_data_path.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_sdp_data_path
FLIST     ?= flist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
